//--- filelist.f
logic/block_pkg.sv
logic/piece_shapes.sv
logic/row_arbiter.sv
logic/board_store.sv
logic/move_checker.sv
logic/piece_locker.sv
logic/line_clearer.sv
logic/playfield_top.sv
verification/playfield_asserts.sv
verification/playfield_tb.sv

//--- logic/block_pkg.sv
`default_nettype none

package block_pkg;

    localparam int BOARD_COLS = 10;
    localparam int BOARD_ROWS = 24;           // Row 0 is the top of the well
    localparam int ROW_W = 5;
    localparam int COL_W = 4;
    localparam int SPAN_W = 4 + (1 << COL_W) - 1;   // One mask row at the widest column offset

    // Row port owners, lower index wins
    localparam int NUM_PORTS = 3;
    localparam int PORT_CLEAR = 0;
    localparam int PORT_LOCK = 1;
    localparam int PORT_CHECK = 2;

    typedef enum logic [2:0] {I, O, T, S, Z, J, L} piece_kind_t;

    typedef struct packed {
        piece_kind_t        kind;
        logic [1:0]         rot;    // Clockwise quarter turns
        logic [COL_W-1:0]   col;    // Left edge of the 4x4 mask
        logic [ROW_W-1:0]   row;    // Top edge of the 4x4 mask
    } piece_pos_t;

    // Bit 4*r+c is mask row r, mask column c
    typedef logic [15:0] piece_mask_t;

    typedef struct packed {
        logic [ROW_W-1:0]       addr;
        logic                   we;
        logic [BOARD_COLS-1:0]  wdata;  // Bit c is column c
    } row_bus_t;

    typedef logic [BOARD_ROWS*BOARD_COLS-1:0] board_t;

    // Places one mask row on the board columns; bits at BOARD_COLS and up fall off the right edge
    function automatic logic [SPAN_W-1:0] row_span(input logic [3:0] cells,
                                                   input logic [COL_W-1:0] col);
        row_span = {{(SPAN_W-4){1'b0}}, cells} << col;
    endfunction

endpackage

`default_nettype wire

//--- logic/board_store.sv
`timescale 1ns/1ps
`default_nettype none

module board_store (
    input  logic                              clk,
    input  logic                              reset,
    input  block_pkg::row_bus_t               bus,
    output logic [block_pkg::BOARD_COLS-1:0]  rdata,
    output block_pkg::board_t                 board_view
);

    logic [block_pkg::BOARD_COLS-1:0] rows [block_pkg::BOARD_ROWS];

    // Read data is the old row when the same row is written this cycle
    always_comb
    begin
        if (bus.addr < block_pkg::ROW_W'(block_pkg::BOARD_ROWS))
            rdata = rows[bus.addr];
        else
            rdata = '0;     // Below the floor reads empty
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int r = 0; r < block_pkg::BOARD_ROWS; r++)
            begin
                rows[r] <= '0;
            end
        end
        else if (bus.we && bus.addr < block_pkg::ROW_W'(block_pkg::BOARD_ROWS))
        begin
            rows[bus.addr] <= bus.wdata;
        end
    end

    // Flat view for the renderer
    always_comb
    begin
        for (int r = 0; r < block_pkg::BOARD_ROWS; r++)
        begin
            board_view[r*block_pkg::BOARD_COLS +: block_pkg::BOARD_COLS] = rows[r];
        end
    end

endmodule

`default_nettype wire

//--- logic/line_clearer.sv
`timescale 1ns/1ps
`default_nettype none

module line_clearer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  logic                              grant,
    input  logic [block_pkg::BOARD_COLS-1:0]  rdata,
    output logic                              req,
    output block_pkg::row_bus_t               bus,
    output logic                              clear_done,
    output logic [2:0]                        lines_cleared
);

    typedef enum logic [1:0] {IDLE, READ, MOVE, ZERO} clear_state_t;

    clear_state_t                       state;
    clear_state_t                       phase;
    logic [block_pkg::ROW_W-1:0]        rptr;
    logic [block_pkg::ROW_W-1:0]        wptr;
    logic [2:0]                         count;
    logic [2:0]                         count_next;
    logic [block_pkg::BOARD_COLS-1:0]   hold;       // Row on its way down
    logic                               full;
    logic                               scan_end;
    logic                               finish;

    // Start cycle already reads the bottom row so the port never goes idle after a lock
    assign phase = (state == IDLE && start) ? READ : state;
    assign req = phase != IDLE;
    assign full = &rdata;

    assign count_next = (phase == READ && full) ? count + 3'd1 : count;
    assign scan_end = rptr == '0
                   && ((phase == READ && (full || rptr == wptr)) || phase == MOVE);
    assign finish = grant
                 && ((phase == ZERO && wptr == '0) || (scan_end && count_next == 3'd0));

    always_comb
    begin
        bus.addr = rptr;
        bus.we = 1'b0;
        bus.wdata = hold;
        case (phase)
            MOVE:
            begin
                bus.addr = wptr;
                bus.we = 1'b1;
            end
            ZERO:
            begin
                bus.addr = wptr;
                bus.we = 1'b1;
                bus.wdata = '0;     // Vacated top rows
            end
            default:
            begin
                bus.addr = rptr;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            rptr <= block_pkg::ROW_W'(block_pkg::BOARD_ROWS - 1);
            wptr <= block_pkg::ROW_W'(block_pkg::BOARD_ROWS - 1);
            count <= '0;
            clear_done <= 1'b0;
            lines_cleared <= '0;
        end
        else
        begin
            clear_done <= 1'b0;
            state <= phase;
            if (grant)
            begin
                count <= count_next;
                case (phase)
                    READ:
                    begin
                        if (!full && rptr != wptr)
                            state <= MOVE;      // Needs a second cycle at wptr
                        else
                        begin
                            if (!full)
                                wptr <= wptr - 1'b1;
                            if (rptr != '0)
                                rptr <= rptr - 1'b1;
                        end
                    end
                    MOVE:
                    begin
                        wptr <= wptr - 1'b1;
                        state <= READ;
                        if (rptr != '0)
                            rptr <= rptr - 1'b1;
                    end
                    ZERO: wptr <= wptr - 1'b1;
                    default: state <= phase;
                endcase
                if (scan_end)
                    state <= ZERO;
                if (finish)
                begin
                    state <= IDLE;
                    rptr <= block_pkg::ROW_W'(block_pkg::BOARD_ROWS - 1);
                    wptr <= block_pkg::ROW_W'(block_pkg::BOARD_ROWS - 1);
                    count <= '0;
                    clear_done <= 1'b1;
                    lines_cleared <= count_next;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (grant && phase == READ)
            hold <= rdata;
    end

endmodule

`default_nettype wire

//--- logic/move_checker.sv
`timescale 1ns/1ps
`default_nettype none

module move_checker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              check,
    input  block_pkg::piece_pos_t             piece,
    input  block_pkg::piece_mask_t            mask,
    input  logic                              grant,
    input  logic [block_pkg::BOARD_COLS-1:0]  rdata,
    output logic                              req,
    output block_pkg::row_bus_t               bus,
    output logic                              check_done,
    output logic                              fits
);

    logic                               active;
    logic [1:0]                         idx;        // Mask row under test
    logic                               hit;
    block_pkg::piece_pos_t              pos_q;
    block_pkg::piece_mask_t             mask_q;
    logic [block_pkg::ROW_W:0]          row_abs;    // One extra bit so row+3 never wraps
    logic                               in_board;
    logic [3:0]                         cells;
    logic [block_pkg::SPAN_W-1:0]       span;
    logic                               row_hit;
    logic                               step;

    assign row_abs = {1'b0, pos_q.row} + {{(block_pkg::ROW_W-1){1'b0}}, idx};
    assign in_board = row_abs < (block_pkg::ROW_W+1)'(block_pkg::BOARD_ROWS);
    assign cells = mask_q[4*idx +: 4];
    assign span = block_pkg::row_span(cells, pos_q.col);

    // Rows below the floor are not read, any cell there is a collision
    always_comb
    begin
        if (in_board)
            row_hit = (|span[block_pkg::SPAN_W-1:block_pkg::BOARD_COLS])
                    || (|(span[block_pkg::BOARD_COLS-1:0] & rdata));
        else
            row_hit = |cells;
    end

    assign req = active && in_board;
    assign step = active && (grant || !in_board);

    always_comb
    begin
        bus.addr = row_abs[block_pkg::ROW_W-1:0];
        bus.we = 1'b0;                  // Read only
        bus.wdata = '0;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= 1'b0;
            idx <= '0;
            hit <= 1'b0;
            check_done <= 1'b0;
            fits <= 1'b0;
        end
        else
        begin
            check_done <= 1'b0;
            fits <= 1'b0;
            if (!active && check)
            begin
                active <= 1'b1;
                idx <= '0;
                hit <= 1'b0;
            end
            else if (step)
            begin
                hit <= hit | row_hit;
                idx <= idx + 2'd1;
                if (idx == 2'd3)
                begin
                    active <= 1'b0;
                    check_done <= 1'b1;
                    fits <= !(hit || row_hit);
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!active && check)
        begin
            pos_q <= piece;
            mask_q <= mask;
        end
    end

endmodule

`default_nettype wire

//--- logic/piece_locker.sv
`timescale 1ns/1ps
`default_nettype none

module piece_locker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              lock,
    input  block_pkg::piece_pos_t             piece,
    input  block_pkg::piece_mask_t            mask,
    input  logic                              grant,
    input  logic [block_pkg::BOARD_COLS-1:0]  rdata,
    input  logic                              clear_done,
    output logic                              req,
    output block_pkg::row_bus_t               bus,
    output logic                              clear_start,
    output logic                              busy
);

    logic                               active;
    logic [1:0]                         idx;
    block_pkg::piece_pos_t              pos_q;
    block_pkg::piece_mask_t             mask_q;
    logic [block_pkg::ROW_W:0]          row_abs;
    logic                               in_board;
    logic [block_pkg::SPAN_W-1:0]       span;

    assign row_abs = {1'b0, pos_q.row} + {{(block_pkg::ROW_W-1){1'b0}}, idx};
    assign in_board = row_abs < (block_pkg::ROW_W+1)'(block_pkg::BOARD_ROWS);
    assign span = block_pkg::row_span(mask_q[4*idx +: 4], pos_q.col);

    // Port stays held through the whole merge so no check slips in between rows
    assign req = active;

    always_comb
    begin
        bus.addr = row_abs[block_pkg::ROW_W-1:0];
        bus.we = in_board;                                          // No write below the floor
        bus.wdata = rdata | span[block_pkg::BOARD_COLS-1:0];        // Cells past column 9 drop
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= 1'b0;
            idx <= '0;
            busy <= 1'b0;
            clear_start <= 1'b0;
        end
        else
        begin
            clear_start <= 1'b0;
            if (lock && !busy)
            begin
                active <= 1'b1;
                busy <= 1'b1;
                idx <= '0;
            end
            else if (active && grant)
            begin
                idx <= idx + 2'd1;
                if (idx == 2'd3)
                begin
                    active <= 1'b0;
                    clear_start <= 1'b1;    // Hand over to the clearer
                end
            end
            if (clear_done)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (lock && !busy)
        begin
            pos_q <= piece;
            mask_q <= mask;
        end
    end

endmodule

`default_nettype wire

//--- logic/piece_shapes.sv
`timescale 1ns/1ps
`default_nettype none

module piece_shapes (
    input  block_pkg::piece_kind_t kind,
    input  logic [1:0]             rot,
    output block_pkg::piece_mask_t mask
);

    block_pkg::piece_mask_t base;

    // Cell (r, c) moves to (c, 3-r)
    function automatic block_pkg::piece_mask_t rotate_cw(input block_pkg::piece_mask_t m);
        block_pkg::piece_mask_t turned;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                turned[4*c + 3 - r] = m[4*r + c];
            end
        end
        return turned;
    endfunction

    always_comb
    begin
        case (kind)
            block_pkg::I: base = 16'h00f0;   // Flat bar in mask row 1
            block_pkg::O: base = 16'h0066;
            block_pkg::T: base = 16'h0027;
            block_pkg::S: base = 16'h0036;
            block_pkg::Z: base = 16'h0063;
            block_pkg::J: base = 16'h0047;
            block_pkg::L: base = 16'h0017;
            default:      base = '0;
        endcase
    end

    always_comb
    begin
        mask = base;
        for (int i = 0; i < 3; i++)
        begin
            if (2'(i) < rot)
                mask = rotate_cw(mask);
        end
    end

endmodule

`default_nettype wire

//--- logic/playfield_top.sv
`timescale 1ns/1ps
`default_nettype none

module playfield_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  check,
    input  logic                  lock,
    input  block_pkg::piece_pos_t piece,
    output logic                  check_done,
    output logic                  fits,
    output logic                  clear_done,
    output logic                  busy,
    output logic [2:0]            lines_cleared,
    output block_pkg::board_t     board_view
);

    block_pkg::piece_mask_t             mask;
    logic [block_pkg::NUM_PORTS-1:0]    req;
    logic [block_pkg::NUM_PORTS-1:0]    grant;
    block_pkg::row_bus_t                port_bus [block_pkg::NUM_PORTS];
    block_pkg::row_bus_t                granted_bus;
    logic [block_pkg::BOARD_COLS-1:0]   rdata;
    logic                               clear_start;

    // One lookup serves both the checker and the locker
    piece_shapes u_shapes (
        .kind (piece.kind),
        .rot  (piece.rot),
        .mask (mask)
    );

    row_arbiter u_arbiter (
        .req     (req),
        .bus_in  (port_bus),
        .grant   (grant),
        .bus_out (granted_bus)
    );

    board_store u_store (
        .clk        (clk),
        .reset      (reset),
        .bus        (granted_bus),
        .rdata      (rdata),
        .board_view (board_view)
    );

    move_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .check      (check),
        .piece      (piece),
        .mask       (mask),
        .grant      (grant[block_pkg::PORT_CHECK]),
        .rdata      (rdata),
        .req        (req[block_pkg::PORT_CHECK]),
        .bus        (port_bus[block_pkg::PORT_CHECK]),
        .check_done (check_done),
        .fits       (fits)
    );

    piece_locker u_locker (
        .clk         (clk),
        .reset       (reset),
        .lock        (lock),
        .piece       (piece),
        .mask        (mask),
        .grant       (grant[block_pkg::PORT_LOCK]),
        .rdata       (rdata),
        .clear_done  (clear_done),
        .req         (req[block_pkg::PORT_LOCK]),
        .bus         (port_bus[block_pkg::PORT_LOCK]),
        .clear_start (clear_start),
        .busy        (busy)
    );

    line_clearer u_clearer (
        .clk           (clk),
        .reset         (reset),
        .start         (clear_start),
        .grant         (grant[block_pkg::PORT_CLEAR]),
        .rdata         (rdata),
        .req           (req[block_pkg::PORT_CLEAR]),
        .bus           (port_bus[block_pkg::PORT_CLEAR]),
        .clear_done    (clear_done),
        .lines_cleared (lines_cleared)
    );

endmodule

`default_nettype wire

//--- logic/row_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module row_arbiter (
    input  logic [block_pkg::NUM_PORTS-1:0] req,
    input  block_pkg::row_bus_t             bus_in [block_pkg::NUM_PORTS],
    output logic [block_pkg::NUM_PORTS-1:0] grant,
    output block_pkg::row_bus_t             bus_out
);

    // Walk from the lowest priority up so the lowest index requester is the last to land
    always_comb
    begin
        grant = '0;
        bus_out = '0;   // Idle bus never writes
        for (int i = block_pkg::NUM_PORTS - 1; i >= 0; i--)
        begin
            if (req[i])
            begin
                grant = '0;
                grant[i] = 1'b1;
                bus_out = bus_in[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build the playfield testbench with Verilator, run it, and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module playfield_tb \
    -f filelist.f --Mdir obj_dir -o playfield_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Raised error limit lets the testbench report a bound assertion failure itself
./obj_dir/playfield_sim +verilator+error+limit+10 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- verification/playfield_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module playfield_asserts (
    input logic                             clk,
    input logic                             reset,
    input logic [block_pkg::NUM_PORTS-1:0]  grant,
    input logic                             check_done,
    input logic                             fits,
    input logic                             clear_done,
    input logic                             busy,
    input logic [2:0]                       lines_cleared
);

    // Sticky flags, one per property
    logic grant_bad = 1'b0;
    logic check_pulse_bad = 1'b0;
    logic clear_pulse_bad = 1'b0;
    logic fits_bad = 1'b0;
    logic lines_bad = 1'b0;
    logic reset_bad = 1'b0;
    logic any_failure;

    assign any_failure = grant_bad | check_pulse_bad | clear_pulse_bad
                       | fits_bad | lines_bad | reset_bad;

    grant_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
    else
    begin
        grant_bad = 1'b1;
        $error("Row port granted to more than one engine");
    end

    check_done_pulse: assert property (@(posedge clk) disable iff (reset)
                                       check_done |=> !check_done)
    else
    begin
        check_pulse_bad = 1'b1;
        $error("check_done held longer than one cycle");
    end

    clear_done_pulse: assert property (@(posedge clk) disable iff (reset)
                                       clear_done |=> !clear_done)
    else
    begin
        clear_pulse_bad = 1'b1;
        $error("clear_done held longer than one cycle");
    end

    fits_with_done: assert property (@(posedge clk) disable iff (reset) fits |-> check_done)
    else
    begin
        fits_bad = 1'b1;
        $error("fits high outside check_done");
    end

    lines_in_range: assert property (@(posedge clk) disable iff (reset) lines_cleared <= 3'd4)
    else
    begin
        lines_bad = 1'b1;
        $error("lines_cleared above four");
    end

    // Reset values show up right after a reset edge
    quiet_after_reset: assert property (@(posedge clk) reset |=>
        (!check_done && !fits && !clear_done && !busy && lines_cleared == 3'd0))
    else
    begin
        reset_bad = 1'b1;
        $error("Control outputs not cleared by reset");
    end

endmodule

bind playfield_top playfield_asserts u_asserts (
    .clk           (clk),
    .reset         (reset),
    .grant         (grant),
    .check_done    (check_done),
    .fits          (fits),
    .clear_done    (clear_done),
    .busy          (busy),
    .lines_cleared (lines_cleared)
);

`default_nettype wire

//--- verification/playfield_tb.sv
`timescale 1ns/1ps
`default_nettype none

module playfield_tb;

    localparam int NUM_RANDOM = 150;
    // About 60 cycles per operation plus the directed tests and some margin
    localparam int MAX_CYCLES = (NUM_RANDOM + 50) * 60 + 8000;

    logic                   clk;
    logic                   reset;
    logic                   check;
    logic                   lock;
    block_pkg::piece_pos_t  piece;
    logic                   check_done;
    logic                   fits;
    logic                   clear_done;
    logic                   busy;
    logic [2:0]             lines_cleared;
    block_pkg::board_t      board_view;

    logic [block_pkg::BOARD_COLS-1:0]   model_rows [block_pkg::BOARD_ROWS];   // Row 0 on top
    logic                               fits_q [$];
    logic [2:0]                         lines_q [$];
    block_pkg::board_t                  board_q [$];
    logic                               want_fits;
    logic [2:0]                         want_lines;
    block_pkg::board_t                  want_board;
    int                                 cycle_count = 0;
    logic [31:0]                        rng;

    playfield_top DUT (
        .clk           (clk),
        .reset         (reset),
        .check         (check),
        .lock          (lock),
        .piece         (piece),
        .check_done    (check_done),
        .fits          (fits),
        .clear_done    (clear_done),
        .busy          (busy),
        .lines_cleared (lines_cleared),
        .board_view    (board_view)
    );

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Piece table as {mask row 1, mask row 0} with bit c as mask column c
    function automatic block_pkg::piece_mask_t shape_of(input int kind, input int rot);
        logic [7:0]             pair;
        block_pkg::piece_mask_t m;
        block_pkg::piece_mask_t turned;
        case (kind)
            0: pair = {4'b1111, 4'b0000};   // I lies in the second row
            1: pair = {4'b0110, 4'b0110};
            2: pair = {4'b0010, 4'b0111};
            3: pair = {4'b0011, 4'b0110};
            4: pair = {4'b0110, 4'b0011};
            5: pair = {4'b0100, 4'b0111};
            6: pair = {4'b0001, 4'b0111};
            default: pair = '0;
        endcase
        m = {8'h00, pair};
        for (int n = 0; n < rot; n++)
        begin
            turned = '0;
            for (int r = 0; r < 4; r++)
            begin
                for (int c = 0; c < 4; c++)
                begin
                    if (m[4*r + c])
                        turned[4*c + 3 - r] = 1'b1;     // (r, c) goes to (c, 3-r)
                end
            end
            m = turned;
        end
        return m;
    endfunction

    function automatic logic piece_fits(input block_pkg::piece_mask_t m, input int col,
                                        input int row);
        logic ok;
        ok = 1'b1;
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                if (m[4*r + c])
                begin
                    if (col + c >= block_pkg::BOARD_COLS || row + r >= block_pkg::BOARD_ROWS)
                        ok = 1'b0;
                    else if (model_rows[row + r][col + c])
                        ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    function automatic void merge_piece(input block_pkg::piece_mask_t m, input int col,
                                        input int row);
        for (int r = 0; r < 4; r++)
        begin
            for (int c = 0; c < 4; c++)
            begin
                if (m[4*r + c] && col + c < block_pkg::BOARD_COLS
                        && row + r < block_pkg::BOARD_ROWS)
                    model_rows[row + r][col + c] = 1'b1;
            end
        end
    endfunction

    // Drops full rows and returns how many went
    function automatic int compact_rows();
        logic [block_pkg::BOARD_COLS-1:0] kept [block_pkg::BOARD_ROWS];
        int w;
        int n;
        w = block_pkg::BOARD_ROWS - 1;
        n = 0;
        for (int r = block_pkg::BOARD_ROWS - 1; r >= 0; r--)
        begin
            if (&model_rows[r])
                n++;
            else
            begin
                kept[w] = model_rows[r];
                w--;
            end
        end
        for (int r = w; r >= 0; r--)
            kept[r] = '0;
        for (int r = 0; r < block_pkg::BOARD_ROWS; r++)
            model_rows[r] = kept[r];
        return n;
    endfunction

    function automatic block_pkg::board_t flatten_board();
        block_pkg::board_t b;
        for (int r = 0; r < block_pkg::BOARD_ROWS; r++)
            b[r*block_pkg::BOARD_COLS +: block_pkg::BOARD_COLS] = model_rows[r];
        return b;
    endfunction

    task automatic report_mismatch(input string name, input block_pkg::board_t expected,
                                   input block_pkg::board_t actual);
        $display("Error: time %0t, signal %s, expected %0h, got %0h",
                 $time, name, expected, actual);
        $display("Test FAILED");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic abort_run(input string why);
        $display("%s, at time %0t", why, $time);
        $display("Test FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic set_piece(input int kind, input int rot, input int col, input int row);
        piece.kind = block_pkg::piece_kind_t'(kind);
        piece.rot = 2'(rot);
        piece.col = block_pkg::COL_W'(col);
        piece.row = block_pkg::ROW_W'(row);
    endtask

    task automatic start_check(input int kind, input int rot, input int col, input int row);
        @(posedge clk);
        #2;
        set_piece(kind, rot, col, row);
        check = 1'b1;
        fits_q.push_back(piece_fits(shape_of(kind, rot), col, row));
        @(posedge clk);
        #2;
        check = 1'b0;
    endtask

    // Model moves straight to the board after the clear
    task automatic start_lock(input int kind, input int rot, input int col, input int row);
        int n;
        @(posedge clk);
        #2;
        set_piece(kind, rot, col, row);
        lock = 1'b1;
        merge_piece(shape_of(kind, rot), col, row);
        n = compact_rows();
        lines_q.push_back(3'(n));
        board_q.push_back(flatten_board());
        @(posedge clk);
        #2;
        lock = 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (fits_q.size() != 0 || lines_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic check_piece(input int kind, input int rot, input int col, input int row);
        start_check(kind, rot, col, row);
        wait_idle();
    endtask

    task automatic lock_piece(input int kind, input int rot, input int col, input int row);
        start_lock(kind, rot, col, row);
        wait_idle();
    endtask

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
            abort_run("Timeout, the DUT stopped answering");
    end

    // Outputs are settled at the falling edge
    always @(negedge clk)
    begin
        if (!reset && check_done)
        begin
            assert (fits_q.size() != 0)
            else abort_run("check_done pulsed with no check pending");
            want_fits = fits_q.pop_front();
            assert (fits === want_fits)
            else report_mismatch("fits", block_pkg::board_t'(want_fits),
                                 block_pkg::board_t'(fits));
        end
        if (!reset && clear_done)
        begin
            assert (lines_q.size() != 0)
            else abort_run("clear_done pulsed with no lock pending");
            want_lines = lines_q.pop_front();
            want_board = board_q.pop_front();
            assert (lines_cleared === want_lines)
            else report_mismatch("lines_cleared", block_pkg::board_t'(want_lines),
                                 block_pkg::board_t'(lines_cleared));
            assert (board_view === want_board)
            else report_mismatch("board_view", want_board, board_view);
            // Busy spans the whole lock up to and including clear_done
            assert (busy === 1'b1)
            else report_mismatch("busy", block_pkg::board_t'(1'b1),
                                 block_pkg::board_t'(busy));
        end
        assert (!DUT.u_asserts.any_failure)
        else abort_run("A bound protocol assertion failed");
    end

    initial
    begin
        int kind;
        int rot;
        int col;
        int row;
        int op;
        reset = 1'b1;
        check = 1'b0;
        lock = 1'b0;
        piece = '0;
        rng = 32'hb550;
        for (int r = 0; r < block_pkg::BOARD_ROWS; r++)
            model_rows[r] = '0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        @(negedge clk);
        assert (board_view === '0)
        else report_mismatch("board_view", '0, board_view);
        assert (busy === 1'b0)
        else report_mismatch("busy", '0, block_pkg::board_t'(busy));

        // Empty board and then the edges of the well
        for (int k = 0; k < 7; k++)
        begin
            for (int r = 0; r < 4; r++)
                check_piece(k, r, 0, 0);
        end
        check_piece(block_pkg::I, 0, 7, 0);     // Bar reaches column 10
        check_piece(block_pkg::I, 1, 0, 21);    // Upright bar reaches row 24
        check_piece(block_pkg::O, 0, 3, 23);

        lock_piece(block_pkg::I, 0, 0, 22);
        lock_piece(block_pkg::I, 0, 0, 20);
        lock_piece(block_pkg::O, 0, 4, 18);
        check_piece(block_pkg::I, 0, 2, 22);    // Overlaps row 23
        check_piece(block_pkg::I, 0, 4, 22);

        // Rows 21 and 23 fill together while row 22 keeps a gap
        lock_piece(block_pkg::I, 0, 4, 22);
        lock_piece(block_pkg::I, 0, 4, 20);
        lock_piece(block_pkg::I, 1, 6, 20);
        lock_piece(block_pkg::I, 1, 7, 20);

        // Check that only fits once row 23 is gone
        lock_piece(block_pkg::I, 0, 0, 22);
        start_lock(block_pkg::I, 0, 4, 22);
        start_check(block_pkg::I, 0, 0, 22);
        wait_idle();

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            rng = next_random(rng);
            kind = int'(rng[7:0]) % 7;
            rot = int'(rng[9:8]);
            col = int'(rng[15:12]) % 10;
            row = 12 + int'(rng[23:16]) % 12;      // Lower half so lines do fill
            op = int'(rng[31:30]);
            if (op < 2)
                check_piece(kind, rot, col, row);
            else if (op == 2)
                lock_piece(kind, rot, col, row);
            else
            begin
                start_lock(kind, rot, col, row);
                start_check(kind, (rot + 1) % 4, col, row);
                wait_idle();
            end
        end

        if (DUT.u_asserts.any_failure)
            abort_run("A bound protocol assertion failed");
        else
        begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
